// File: design/sched_defs.svh
//--------------------------------------------------------------------------
// pagerank scheduler constants
// vector sizes, memory word split and host address map
//--------------------------------------------------------------------------

`default_nettype none

`ifndef SCHED_DEFS_SVH
`define SCHED_DEFS_SVH

// vector and word geometry
`define SCHED_N           8
`define SCHED_NBITS       8
`define SCHED_BW          32
`define SCHED_LANES       4
`define SCHED_CHUNKS      2
`define SCHED_ADDR_W      32

// host address map
`define SCHED_ADDR_GO     32'd0
`define SCHED_ADDR_BASE_G 32'd1
`define SCHED_ADDR_BASE_R 32'd2
// first of N result slots
`define SCHED_ADDR_RESULT 32'd4

`endif

`default_nettype wire

// File: design/pagerank_pkg.sv
//--------------------------------------------------------------------------
// pagerank scheduler types
// host and memory message layouts, message and FSM encodings
//--------------------------------------------------------------------------

`include "sched_defs.svh"

`default_nettype none

package pagerank_pkg;

  // host message type, same encoding as the memory side
  typedef enum logic {
    pr_read  = 1'b0,
    pr_write = 1'b1
  } pr_type_e;

  typedef enum logic [2:0] {
    mem_read  = 3'd0,
    mem_write = 3'd1
  } mem_type_e;

  // controller FSM
  typedef enum logic [2:0] {
    st_idle,
    st_read_r,
    st_wait_r,
    st_read_g,
    st_wait_g
  } sched_state_e;

  //------------------------------------------------------------------------
  // messages, type field in the msb
  //------------------------------------------------------------------------

  typedef struct packed {
    pr_type_e                 msg_type;
    logic [`SCHED_ADDR_W-1:0] addr;
    logic [`SCHED_BW-1:0]     data;
  } pr_req_t;

  typedef struct packed {
    pr_type_e             msg_type;
    logic [`SCHED_BW-1:0] data;
  } pr_resp_t;

  typedef struct packed {
    mem_type_e                msg_type;
    logic [`SCHED_ADDR_W-1:0] addr;
    logic [`SCHED_BW-1:0]     data;
  } mem_req_t;

  typedef struct packed {
    mem_type_e            msg_type;
    logic [`SCHED_BW-1:0] data;
  } mem_resp_t;

endpackage

`default_nettype wire

// File: design/sched_host_port.sv
//--------------------------------------------------------------------------
// host port of the pagerank scheduler
// decodes host requests, holds base addresses, answers in the same cycle
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "sched_defs.svh"

`default_nettype none

module sched_host_port
  import pagerank_pkg::*;
(
  input  wire                          clk,
  input  wire                          reset,

  // host request / response
  input  wire pr_req_t                 pr_req,
  input  wire                          pr_req_val,
  output logic                         pr_req_rdy,
  output pr_resp_t                     pr_resp,
  output logic                         pr_resp_val,
  input  wire                          pr_resp_rdy,

  // controller side
  input  wire                          busy,
  output logic                         go,
  output logic [`SCHED_ADDR_W-1:0]     base_g,
  output logic [`SCHED_ADDR_W-1:0]     base_r,

  // datapath side
  output logic [$clog2(`SCHED_N)-1:0]  result_idx,
  input  wire  [`SCHED_NBITS-1:0]      result_byte
);

  localparam int unsigned idx_w = $clog2(`SCHED_N);

  logic req_go;
  logic is_write;
  logic in_window;
  logic load_base_g;
  logic load_base_r;

  //------------------------------------------------------------------------
  // handshake, closed while a run is going
  //------------------------------------------------------------------------

  // request only taken when the response can leave too
  assign pr_req_rdy  = !busy && pr_resp_rdy;
  assign pr_resp_val = !busy && pr_req_val;

  assign req_go   = pr_req_val && pr_req_rdy;
  assign is_write = (pr_req.msg_type == pr_write);

  //------------------------------------------------------------------------
  // address decode
  //------------------------------------------------------------------------

  assign go          = req_go && is_write && (pr_req.addr == `SCHED_ADDR_GO);
  assign load_base_g = req_go && is_write && (pr_req.addr == `SCHED_ADDR_BASE_G);
  assign load_base_r = req_go && is_write && (pr_req.addr == `SCHED_ADDR_BASE_R);

  // result window, N slots from the first result address
  assign in_window = (pr_req.addr >= `SCHED_ADDR_RESULT) &&
                     (pr_req.addr <  `SCHED_ADDR_RESULT + `SCHED_N);

  // offset into the window, low bits are enough
  assign result_idx = pr_req.addr[idx_w-1:0] - idx_w'(`SCHED_ADDR_RESULT);

  //------------------------------------------------------------------------
  // base address registers
  //------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      base_g <= '0;
      base_r <= '0;
    end else begin
      if (load_base_g) begin
        base_g <= pr_req.data;
      end
      if (load_base_r) begin
        base_r <= pr_req.data;
      end
    end
  end

  //------------------------------------------------------------------------
  // response
  //------------------------------------------------------------------------

  // echo the type, data only for reads inside the window
  always_comb begin
    pr_resp.msg_type = pr_req.msg_type;
    pr_resp.data     = '0;
    if (!is_write && in_window) begin
      pr_resp.data = `SCHED_BW'(result_byte);
    end
  end

endmodule

`default_nettype wire

// File: design/sched_ctrl.sv
//--------------------------------------------------------------------------
// pagerank scheduler controller
// walks chunks and rows, issues memory reads, steers the datapath loads
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "sched_defs.svh"

`default_nettype none

module sched_ctrl
  import pagerank_pkg::*;
(
  input  wire                          clk,
  input  wire                          reset,

  // from host port
  input  wire                          go,
  input  wire  [`SCHED_ADDR_W-1:0]     base_g,
  input  wire  [`SCHED_ADDR_W-1:0]     base_r,
  output logic                         busy,

  // memory request / response
  output mem_req_t                     mem_req,
  output logic                         mem_req_val,
  input  wire                          mem_req_rdy,
  input  wire mem_resp_t               mem_resp,
  input  wire                          mem_resp_val,
  output logic                         mem_resp_rdy,

  // datapath control
  output logic                         clear,
  output logic                         r_load,
  output logic                         g_load,
  output logic [$clog2(`SCHED_N)-1:0]  row
);

  localparam int unsigned idx_w      = $clog2(`SCHED_N);
  localparam int unsigned chunk_w    = $clog2(`SCHED_CHUNKS);
  localparam int unsigned word_bytes = `SCHED_BW / 8;
  localparam int unsigned row_bytes  = `SCHED_N * `SCHED_NBITS / 8;

  sched_state_e             state_q;
  sched_state_e             state_d;
  logic [chunk_w-1:0]       chunk_q;
  logic [idx_w-1:0]         row_q;
  logic                     drain_q;
  logic                     clear_q;
  logic                     start;
  logic                     req_go;
  logic                     resp_go;
  logic                     resp_is_read;
  logic                     last_row;
  logic                     last_chunk;
  logic                     g_done;
  logic [`SCHED_ADDR_W-1:0] addr_r;
  logic [`SCHED_ADDR_W-1:0] addr_g;

  assign start        = go && (state_q == st_idle);
  assign req_go       = mem_req_val && mem_req_rdy;
  assign resp_go      = mem_resp_val && mem_resp_rdy;
  assign resp_is_read = (mem_resp.msg_type == mem_read);
  assign last_row     = (row_q == idx_w'(`SCHED_N - 1));
  assign last_chunk   = (chunk_q == chunk_w'(`SCHED_CHUNKS - 1));

  // g word of a row taken in
  assign g_done = (state_q == st_wait_g) && resp_go;

  //------------------------------------------------------------------------
  // address generation
  //------------------------------------------------------------------------

  // r word per chunk
  assign addr_r = base_r + `SCHED_ADDR_W'(chunk_q) * word_bytes;

  // g word, row stride then chunk offset
  assign addr_g = base_g + `SCHED_ADDR_W'(row_q) * row_bytes
                         + `SCHED_ADDR_W'(chunk_q) * word_bytes;

  //------------------------------------------------------------------------
  // next state
  //------------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (go) begin
          state_d = st_read_r;
        end
      end
      st_read_r: begin
        if (req_go) begin
          state_d = st_wait_r;
        end
      end
      st_wait_r: begin
        if (resp_go) begin
          state_d = st_read_g;
        end
      end
      st_read_g: begin
        if (req_go) begin
          state_d = st_wait_g;
        end
      end
      st_wait_g: begin
        if (resp_go) begin
          // more rows, else next chunk, else done
          if (!last_row) begin
            state_d = st_read_g;
          end else if (!last_chunk) begin
            state_d = st_read_r;
          end else begin
            state_d = st_idle;
          end
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  //------------------------------------------------------------------------
  // state, counters, delayed pulses
  //------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= st_idle;
      chunk_q <= '0;
      row_q   <= '0;
      drain_q <= 1'b0;
      clear_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // clear lands in the first read_r cycle
      clear_q <= start;
      // one extra busy cycle for the last accumulate
      drain_q <= g_done && last_row && last_chunk;
      if (start) begin
        chunk_q <= '0;
        row_q   <= '0;
      end else if (g_done) begin
        if (last_row) begin
          row_q   <= '0;
          chunk_q <= last_chunk ? '0 : chunk_q + 1'b1;
        end else begin
          row_q <= row_q + 1'b1;
        end
      end
    end
  end

  //------------------------------------------------------------------------
  // outputs
  //------------------------------------------------------------------------

  assign busy = (state_q != st_idle) || drain_q;

  // request held steady, counters only move on responses
  assign mem_req_val  = (state_q == st_read_r) || (state_q == st_read_g);
  assign mem_resp_rdy = (state_q == st_wait_r) || (state_q == st_wait_g);

  assign mem_req.msg_type = mem_read;
  assign mem_req.addr     = (state_q == st_read_g) ? addr_g : addr_r;
  assign mem_req.data     = '0;

  // loads only for read responses
  assign r_load = (state_q == st_wait_r) && resp_go && resp_is_read;
  assign g_load = g_done && resp_is_read;

  assign clear = clear_q;
  assign row   = row_q;

endmodule

`default_nettype wire

// File: design/dot_datapath.sv
//--------------------------------------------------------------------------
// pagerank dot product datapath
// r lanes, g capture stage, four-lane multiply-accumulate into row results
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "sched_defs.svh"

`default_nettype none

module dot_datapath (
  input  wire                          clk,
  input  wire                          reset,

  // from controller
  input  wire                          clear,
  input  wire                          r_load,
  input  wire                          g_load,
  input  wire  [$clog2(`SCHED_N)-1:0]  row,

  // memory response payload
  input  wire  [`SCHED_BW-1:0]         mem_data,

  // host result read
  input  wire  [$clog2(`SCHED_N)-1:0]  result_idx,
  output logic [`SCHED_NBITS-1:0]      result_byte
);

  localparam int unsigned idx_w = $clog2(`SCHED_N);

  // one byte per lane, lane 0 in the low byte
  logic [`SCHED_LANES-1:0][`SCHED_NBITS-1:0] r_lane_q;
  logic [`SCHED_LANES-1:0][`SCHED_NBITS-1:0] g_lane_q;
  logic [idx_w-1:0]                          g_row_q;
  logic                                      acc_en_q;
  logic [`SCHED_N-1:0][`SCHED_NBITS-1:0]     result_q;
  logic [`SCHED_NBITS-1:0]                   dot;

  //------------------------------------------------------------------------
  // r lanes and g capture
  //------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      r_lane_q <= '0;
      g_lane_q <= '0;
      g_row_q  <= '0;
      acc_en_q <= 1'b0;
    end else begin
      if (r_load) begin
        r_lane_q <= mem_data;
      end
      // g word and its row travel together
      if (g_load) begin
        g_lane_q <= mem_data;
        g_row_q  <= row;
      end
      acc_en_q <= g_load;
    end
  end

  //------------------------------------------------------------------------
  // four-lane dot product, wraps mod 256
  //------------------------------------------------------------------------

  always_comb begin
    dot = '0;
    for (int k = 0; k < `SCHED_LANES; k++) begin
      dot = dot + `SCHED_NBITS'(r_lane_q[k] * g_lane_q[k]);
    end
  end

  //------------------------------------------------------------------------
  // result registers
  //------------------------------------------------------------------------

  // accumulate across chunks, clear starts a new run
  always_ff @(posedge clk) begin
    if (reset) begin
      result_q <= '0;
    end else if (clear) begin
      result_q <= '0;
    end else if (acc_en_q) begin
      result_q[g_row_q] <= result_q[g_row_q] + dot;
    end
  end

  assign result_byte = result_q[result_idx];

endmodule

`default_nettype wire

// File: design/pagerank_sched.sv
//--------------------------------------------------------------------------
// pagerank scheduler top
// joins host port, controller and dot product datapath
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "sched_defs.svh"

`default_nettype none

module pagerank_sched
  import pagerank_pkg::*;
(
  input  wire             clk,
  input  wire             reset,

  // host port
  input  wire pr_req_t    pr_req,
  input  wire             pr_req_val,
  output logic            pr_req_rdy,
  output pr_resp_t        pr_resp,
  output logic            pr_resp_val,
  input  wire             pr_resp_rdy,

  // memory port
  output mem_req_t        mem_req,
  output logic            mem_req_val,
  input  wire             mem_req_rdy,
  input  wire mem_resp_t  mem_resp,
  input  wire             mem_resp_val,
  output logic            mem_resp_rdy
);

  localparam int unsigned idx_w = $clog2(`SCHED_N);

  logic                     go;
  logic                     busy;
  logic [`SCHED_ADDR_W-1:0] base_g;
  logic [`SCHED_ADDR_W-1:0] base_r;
  logic                     clear;
  logic                     r_load;
  logic                     g_load;
  logic [idx_w-1:0]         row;
  logic [idx_w-1:0]         result_idx;
  logic [`SCHED_NBITS-1:0]  result_byte;

  sched_host_port u_host_port (
    .clk         (clk),
    .reset       (reset),
    .pr_req      (pr_req),
    .pr_req_val  (pr_req_val),
    .pr_req_rdy  (pr_req_rdy),
    .pr_resp     (pr_resp),
    .pr_resp_val (pr_resp_val),
    .pr_resp_rdy (pr_resp_rdy),
    .busy        (busy),
    .go          (go),
    .base_g      (base_g),
    .base_r      (base_r),
    .result_idx  (result_idx),
    .result_byte (result_byte)
  );

  sched_ctrl u_ctrl (
    .clk          (clk),
    .reset        (reset),
    .go           (go),
    .base_g       (base_g),
    .base_r       (base_r),
    .busy         (busy),
    .mem_req      (mem_req),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_resp     (mem_resp),
    .mem_resp_val (mem_resp_val),
    .mem_resp_rdy (mem_resp_rdy),
    .clear        (clear),
    .r_load       (r_load),
    .g_load       (g_load),
    .row          (row)
  );

  // response payload straight into the lanes
  dot_datapath u_datapath (
    .clk         (clk),
    .reset       (reset),
    .clear       (clear),
    .r_load      (r_load),
    .g_load      (g_load),
    .row         (row),
    .mem_data    (mem_resp.data),
    .result_idx  (result_idx),
    .result_byte (result_byte)
  );

endmodule

`default_nettype wire

// File: bench/pagerank_sched_props.sv
//--------------------------------------------------------------------------
// pagerank scheduler handshake properties, bound into the top level
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`default_nettype none

module pagerank_sched_props
  import pagerank_pkg::*;
(
  input wire           clk,
  input wire           reset,
  input wire mem_req_t mem_req,
  input wire           mem_req_val,
  input wire           mem_req_rdy,
  input wire           mem_resp_rdy,
  input wire           pr_req_rdy,
  input wire           busy
);

  // a stalled memory request stays up and unchanged
  a_mem_req_hold: assert property (@(posedge clk) disable iff (reset)
    (mem_req_val && !mem_req_rdy) |=> (mem_req_val && $stable(mem_req)))
    else $error("memory request dropped or changed before acceptance");

  // one outstanding read, request and wait never overlap
  a_mem_one_side: assert property (@(posedge clk) disable iff (reset)
    !(mem_req_val && mem_resp_rdy))
    else $error("memory request valid and response ready both high");

  // host closed while a run is going
  a_host_closed: assert property (@(posedge clk) disable iff (reset)
    busy |-> !pr_req_rdy)
    else $error("host request ready while busy");

endmodule

bind pagerank_sched pagerank_sched_props u_props (
  .clk          (clk),
  .reset        (reset),
  .mem_req      (mem_req),
  .mem_req_val  (mem_req_val),
  .mem_req_rdy  (mem_req_rdy),
  .mem_resp_rdy (mem_resp_rdy),
  .pr_req_rdy   (pr_req_rdy),
  .busy         (busy)
);

`default_nettype wire

// File: bench/pagerank_sched_tb.sv
//--------------------------------------------------------------------------
// pagerank scheduler testbench
// random matrices and bases, stalling memory model, checks against a model
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "sched_defs.svh"

`default_nettype none

module pagerank_sched_tb
  import pagerank_pkg::*;
();

  localparam int unsigned num_runs      = 20;
  localparam int unsigned run_cycles    = 300;
  localparam int unsigned cycle_limit   = num_runs * run_cycles;
  localparam int unsigned mem_words     = 256;
  localparam int unsigned reads_per_run = `SCHED_CHUNKS * (1 + `SCHED_N);

  logic      clk = 1'b0;
  logic      reset;
  pr_req_t   pr_req;
  logic      pr_req_val;
  logic      pr_req_rdy;
  pr_resp_t  pr_resp;
  logic      pr_resp_val;
  logic      pr_resp_rdy;
  mem_req_t  mem_req;
  logic      mem_req_val;
  logic      mem_req_rdy;
  mem_resp_t mem_resp;
  logic      mem_resp_val;
  logic      mem_resp_rdy;

  integer                  seed = 32'h99f3b57d;
  int unsigned             cycles = 0;
  logic [`SCHED_BW-1:0]    mem [0:mem_words-1];
  // expected memory reads of this run in issue order
  logic [`SCHED_ADDR_W-1:0] exp_addr_q [$];
  int                      pending_resps = 0;
  logic [`SCHED_NBITS-1:0] model [0:`SCHED_N-1];

  pagerank_sched dut (
    .clk          (clk),
    .reset        (reset),
    .pr_req       (pr_req),
    .pr_req_val   (pr_req_val),
    .pr_req_rdy   (pr_req_rdy),
    .pr_resp      (pr_resp),
    .pr_resp_val  (pr_resp_val),
    .pr_resp_rdy  (pr_resp_rdy),
    .mem_req      (mem_req),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_resp     (mem_resp),
    .mem_resp_val (mem_resp_val),
    .mem_resp_rdy (mem_resp_rdy)
  );

  always #2 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("FAIL: see errors above");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      $display("FAIL: see errors above");
      $fatal(1, "value mismatch");
    end
  endtask

  //------------------------------------------------------------------------
  // reference model
  //------------------------------------------------------------------------

  // little endian byte view of the word memory
  function automatic logic [7:0] mem_byte(input logic [31:0] addr);
    logic [31:0] word;
    word = mem[addr[9:2]];
    return word[addr[1:0]*8 +: 8];
  endfunction

  task automatic fill_memory();
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = $random(seed);
    end
  endtask

  // row j of g is 8 consecutive bytes and r is 8 bytes from its base
  task automatic compute_model(input logic [31:0] bg, input logic [31:0] br);
    logic [7:0] acc;
    for (int j = 0; j < `SCHED_N; j++) begin
      acc = 8'd0;
      for (int m = 0; m < `SCHED_N; m++) begin
        acc = acc + 8'(mem_byte(bg + 32'(8 * j + m)) * mem_byte(br + 32'(m)));
      end
      model[j] = acc;
    end
  endtask

  //------------------------------------------------------------------------
  // memory model serving one read at a time with random stalls
  //------------------------------------------------------------------------

  initial begin : memory_model
    logic [31:0] addr;
    int unsigned delay;
    mem_req_rdy  = 1'b0;
    mem_resp_val = 1'b0;
    mem_resp     = '0;
    forever begin
      // handshakes judged mid cycle and completed at the next edge
      @(negedge clk);
      if (mem_req_val && mem_req_rdy) begin
        addr = mem_req.addr;
        if (exp_addr_q.size() == 0) begin
          $display("memory read at %h with no read expected", addr);
          $display("FAIL: see errors above");
          $fatal(1, "unexpected memory read");
        end
        compare("memory read address", exp_addr_q.pop_front(), addr);
        compare("memory request type", 32'(mem_read), 32'(mem_req.msg_type));
        @(posedge clk);
        #1;
        mem_req_rdy = 1'b0;
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        mem_resp.msg_type = mem_read;
        mem_resp.data     = mem[addr[9:2]];
        mem_resp_val      = 1'b1;
        @(negedge clk);
        while (!mem_resp_rdy) begin
          @(negedge clk);
        end
        pending_resps = pending_resps - 1;
        @(posedge clk);
        #1;
        mem_resp_val = 1'b0;
        mem_req_rdy  = ($random(seed) & 3) != 0;
      end else begin
        @(posedge clk);
        #1;
        mem_req_rdy = ($random(seed) & 3) != 0;
      end
    end
  end

  //------------------------------------------------------------------------
  // host side tasks entered just after a rising edge
  //------------------------------------------------------------------------

  task automatic host_access(input pr_type_e kind, input logic [31:0] addr,
                             input logic [31:0] data, input logic stall,
                             output logic [31:0] rdata);
    logic done;
    done            = 1'b0;
    rdata           = '0;
    pr_req.msg_type = kind;
    pr_req.addr     = addr;
    pr_req.data     = data;
    pr_req_val      = 1'b1;
    pr_resp_rdy     = !stall || (($random(seed) & 3) != 0);
    while (!done) begin
      @(negedge clk);
      if (pr_req_rdy) begin
        // response leaves in the same cycle
        done = 1'b1;
        compare("host response valid", 32'd1, {31'd0, pr_resp_val});
        compare("host response type", 32'(kind), 32'(pr_resp.msg_type));
        rdata = pr_resp.data;
      end
      @(posedge clk);
      #1;
      if (!done) begin
        pr_resp_rdy = !stall || (($random(seed) & 3) != 0);
      end
    end
    pr_req_val = 1'b0;
  endtask

  task automatic host_write(input logic [31:0] addr, input logic [31:0] data,
                            input string name);
    logic [31:0] rdata;
    host_access(pr_write, addr, data, 1'b1, rdata);
    compare(name, 32'd0, rdata);
  endtask

  task automatic host_read(input logic [31:0] addr, output logic [31:0] rdata);
    host_access(pr_read, addr, 32'd0, 1'b1, rdata);
  endtask

  // host always ready, so the read goes in the first cycle the port opens
  task automatic host_read_no_stall(input logic [31:0] addr,
                                    output logic [31:0] rdata);
    host_access(pr_read, addr, 32'd0, 1'b0, rdata);
  endtask

  // expected reads in chunk then row order before the go write
  task automatic start_run(input logic [31:0] bg, input logic [31:0] br);
    exp_addr_q.delete();
    for (int c = 0; c < `SCHED_CHUNKS; c++) begin
      exp_addr_q.push_back(br + 32'(4 * c));
      for (int j = 0; j < `SCHED_N; j++) begin
        exp_addr_q.push_back(bg + 32'(8 * j + 4 * c));
      end
    end
    pending_resps = reads_per_run;
    host_write(`SCHED_ADDR_GO, $random(seed), "go write response");
  endtask

  // end of run shows as pr_req_rdy rising with the host ready
  task automatic wait_run_end();
    pr_resp_rdy = 1'b1;
    @(negedge clk);
    while (!pr_req_rdy) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    compare("memory reads left", 32'd0, 32'(exp_addr_q.size()));
    compare("memory responses left", 32'd0, 32'(pending_resps));
  endtask

  task automatic check_results(input string name);
    logic [31:0] rdata;
    for (int j = 0; j < `SCHED_N; j++) begin
      host_read(`SCHED_ADDR_RESULT + 32'(j), rdata);
      compare($sformatf("%s result %0d", name, j), {24'd0, model[j]}, rdata);
    end
  endtask

  //------------------------------------------------------------------------
  // test sequence
  //------------------------------------------------------------------------

  initial begin : main_sequence
    logic [31:0] rdata;
    logic [31:0] bg;
    logic [31:0] br;
    reset       = 1'b1;
    pr_req      = '0;
    pr_req_val  = 1'b0;
    pr_resp_rdy = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;

    // results clear after reset and writes answer with 0
    for (int j = 0; j < `SCHED_N; j++) begin
      host_read(`SCHED_ADDR_RESULT + 32'(j), rdata);
      compare($sformatf("reset result %0d", j), 32'd0, rdata);
    end
    host_write(`SCHED_ADDR_RESULT, 32'hdeadbeef, "result write response");
    host_write(32'd12, 32'h12345678, "unmapped write response");

    // random matrices and bases
    for (int run = 0; run < num_runs; run++) begin
      fill_memory();
      bg = ($unsigned($random(seed)) % (mem_words - 16)) * 4;
      br = ($unsigned($random(seed)) % (mem_words - 2)) * 4;
      host_write(`SCHED_ADDR_BASE_G, bg, "base g write response");
      host_write(`SCHED_ADDR_BASE_R, br, "base r write response");
      compute_model(bg, br);
      start_run(bg, br);
      wait_run_end();
      check_results($sformatf("run %0d", run));
    end

    // last row read issued during a run is held past the final accumulate
    fill_memory();
    compute_model(bg, br);
    start_run(bg, br);
    host_read_no_stall(`SCHED_ADDR_RESULT + 32'(`SCHED_N - 1), rdata);
    compare("read held during run", 32'd0, 32'(pending_resps));
    compare("read during run last result", {24'd0, model[`SCHED_N-1]}, rdata);
    check_results("held read run");

    // outside the window reads as 0
    host_read(`SCHED_ADDR_GO, rdata);
    compare("read go address", 32'd0, rdata);
    host_read(`SCHED_ADDR_BASE_G, rdata);
    compare("read base g address", 32'd0, rdata);
    host_read(32'd3, rdata);
    compare("read address 3", 32'd0, rdata);
    host_read(32'd12, rdata);
    compare("read address 12", 32'd0, rdata);
    host_read(32'h0000_0104, rdata);
    compare("read far address", 32'd0, rdata);

    // second go on the same data starts from zero
    start_run(bg, br);
    wait_run_end();
    check_results("rerun");

    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+design
design/pagerank_pkg.sv
design/sched_host_port.sv
design/sched_ctrl.sv
design/dot_datapath.sv
design/pagerank_sched.sv
bench/pagerank_sched_props.sv
bench/pagerank_sched_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the pagerank scheduler testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module pagerank_sched_tb -f compile.f -o sim_pagerank

status=0
./obj_dir/sim_pagerank > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "simulation failed"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi
echo "simulation passed"
